/* hdl/maze_pkg.sv */
/*
 * mesh router shared definitions
 *   mesh size and address widths
 *   port index encoding
 *   packet layout and route request vector
 */

package maze_pkg;

    // ========================================================================
    // mesh geometry
    // ========================================================================
    localparam int MESH_DIM  = 8;                  // 8 x 8 mesh
    localparam int COORD_W   = $clog2(MESH_DIM);   // bits per coordinate
    localparam int NODE_ID_W = 2 * COORD_W;        // {y, x}
    localparam int DATA_W    = 8;
    localparam int N_PORTS   = 5;

    // ========================================================================
    // port indices
    // ========================================================================
    // PORT_L is local A on the input side and local B on the output side
    typedef enum logic [2:0] {
        PORT_N = 3'd0,
        PORT_W = 3'd1,
        PORT_S = 3'd2,
        PORT_E = 3'd3,
        PORT_L = 3'd4
    } port_e;

    // ========================================================================
    // packet and route
    // ========================================================================
    typedef struct packed {
        logic                 qos;        // high priority class
        logic [1:0]           pkt_type;   // carried through, not decoded
        logic [NODE_ID_W-1:0] src;
        logic [NODE_ID_W-1:0] tgt;        // low bits x, high bits y
        logic [DATA_W-1:0]    data;
    } pkt_t;

    // one-hot output request, bit index is port_e
    typedef logic [N_PORTS-1:0] route_t;

endpackage

/* hdl/xy_route.sv */
/*
 * xy_route
 *   dimension-ordered route computation for one input port,
 *   x is resolved first, then y, then delivery to local
 */

`timescale 1ns/1ps

module xy_route import maze_pkg::*; #(
    parameter int LOCAL_X = 0,
    parameter int LOCAL_Y = 0
) (
    input  logic [NODE_ID_W-1:0] tgt_i,
    output route_t               route_o
);

    localparam logic [COORD_W-1:0] LX = COORD_W'(LOCAL_X);
    localparam logic [COORD_W-1:0] LY = COORD_W'(LOCAL_Y);

    logic [COORD_W-1:0] tgt_x;
    logic [COORD_W-1:0] tgt_y;

    assign tgt_x = tgt_i[COORD_W-1:0];
    assign tgt_y = tgt_i[NODE_ID_W-1:COORD_W];

    always_comb begin
        route_o = '0;
        if (tgt_x > LX) begin
            route_o[PORT_E] = 1'b1;
        end else if (tgt_x < LX) begin
            route_o[PORT_W] = 1'b1;
        end else if (tgt_y > LY) begin            // x done, move along y
            route_o[PORT_N] = 1'b1;
        end else if (tgt_y < LY) begin
            route_o[PORT_S] = 1'b1;
        end else begin
            route_o[PORT_L] = 1'b1;               // arrived
        end
    end

    // every target must map to exactly one output
    a_route_onehot : assert final ($onehot(route_o))
        else $error("xy_route: route not one-hot for target %0h", tgt_i);

endmodule

/* hdl/input_buffer.sv */
/*
 * input_buffer
 *   one-entry buffer per input port that keeps the packet with its
 *   route request until the selected output grants it
 */

`timescale 1ns/1ps

module input_buffer import maze_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,

    // upstream handshake
    input  logic   vld_i,
    input  pkt_t   pkt_i,
    output logic   rdy_o,

    // route from xy_route, sampled with the packet
    input  route_t route_i,

    // towards the output arbiters
    input  logic   gnt_i,
    output route_t req_o,
    output pkt_t   pkt_o
);

    logic   full_q;
    pkt_t   pkt_q;
    route_t route_q;
    logic   load;

    // free slot or the held packet leaves this cycle
    assign rdy_o = !full_q || gnt_i;
    assign load  = vld_i && rdy_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (gnt_i) begin
            full_q <= 1'b0;
        end
    end

    // payload and route
    always_ff @(posedge clk) begin
        if (load) begin
            pkt_q   <= pkt_i;
            route_q <= route_i;
        end
    end

    assign req_o = route_q & {N_PORTS{full_q}};   // quiet while empty
    assign pkt_o = pkt_q;

    // a grant can only come back for a request that was raised
    a_gnt_when_full : assert property (
        @(posedge clk) disable iff (reset_i)
        gnt_i |-> full_q
    ) else $error("input_buffer: grant while empty");

endmodule

/* hdl/qos_arbiter.sv */
/*
 * qos_arbiter
 *   qos requesters win over plain ones, round-robin inside the
 *   chosen class, pointer moves past the winner on an accepted grant
 */

`timescale 1ns/1ps

module qos_arbiter #(
    parameter int N_REQ = 4
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [N_REQ-1:0] req_i,
    input  logic [N_REQ-1:0] qos_i,
    input  logic             accept_i,   // downstream takes the winner
    output logic [N_REQ-1:0] gnt_o
);

    localparam int PTR_W = $clog2(N_REQ);

    logic [PTR_W-1:0] ptr_q;
    logic [N_REQ-1:0] cand;
    logic [PTR_W-1:0] win_idx;

    // ========================================================================
    // class select and rotating search
    // ========================================================================
    assign cand = (|(req_i & qos_i)) ? (req_i & qos_i) : req_i;

    always_comb begin
        int   idx;
        logic found;
        found   = 1'b0;
        win_idx = '0;
        gnt_o   = '0;
        for (int i = 0; i < N_REQ; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= N_REQ) begin
                idx = idx - N_REQ;                // wrap around
            end
            if (!found && cand[idx]) begin
                found   = 1'b1;
                win_idx = PTR_W'(idx);
            end
        end
        if (found) begin
            gnt_o[win_idx] = 1'b1;
        end
    end

    // ========================================================================
    // round-robin pointer
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (accept_i && (|gnt_o)) begin
            ptr_q <= (win_idx == PTR_W'(N_REQ - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    a_gnt_onehot0 : assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(gnt_o)
    ) else $error("qos_arbiter: more than one grant");

endmodule

/* hdl/output_buffer.sv */
/*
 * output_buffer
 *   one-entry register slice on an output port,
 *   full throughput while the downstream stays ready
 */

`timescale 1ns/1ps

module output_buffer import maze_pkg::*; (
    input  logic clk,
    input  logic reset_i,

    // from the arbiter and winner mux
    input  logic valid_i,
    input  pkt_t pkt_i,
    output logic ready_o,

    // to the neighbor
    output logic valid_o,
    output pkt_t pkt_o,
    input  logic ready_i
);

    logic load;

    assign ready_o = !valid_o || ready_i;   // empty or draining now
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (load) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pkt_o <= pkt_i;
        end
    end

    // stalled output keeps offering the same packet
    a_hold_stable : assert property (
        @(posedge clk) disable iff (reset_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(pkt_o))
    ) else $error("output_buffer: payload changed under back-pressure");

endmodule

/* hdl/output_port.sv */
/*
 * output_port
 *   one output direction: qos round-robin arbiter,
 *   winner multiplexer and output register slice
 */

`timescale 1ns/1ps

module output_port import maze_pkg::*; #(
    parameter int N_REQ = 4
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [N_REQ-1:0] req_i,
    input  pkt_t             pkts_i [N_REQ],
    output logic [N_REQ-1:0] gnt_o,
    output logic             vld_o,
    output pkt_t             pkt_o,
    input  logic             rdy_i
);

    logic [N_REQ-1:0] qos;
    logic [N_REQ-1:0] arb_req;
    logic             obuf_rdy;
    pkt_t             sel_pkt;

    // no arbitration while the slice cannot take a packet
    assign arb_req = req_i & {N_REQ{obuf_rdy}};

    always_comb begin
        sel_pkt = '0;
        for (int j = 0; j < N_REQ; j++) begin
            qos[j] = pkts_i[j].qos;
            if (gnt_o[j]) begin
                sel_pkt = pkts_i[j];               // grant is one-hot
            end
        end
    end

    qos_arbiter #(
        .N_REQ    (N_REQ)
    ) i_arb (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (arb_req),
        .qos_i    (qos),
        .accept_i (obuf_rdy),
        .gnt_o    (gnt_o)
    );

    output_buffer i_obuf (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (|gnt_o),
        .pkt_i    (sel_pkt),
        .ready_o  (obuf_rdy),
        .valid_o  (vld_o),
        .pkt_o    (pkt_o),
        .ready_i  (rdy_i)
    );

endmodule

/* hdl/maze_node.sv */
/*
 * maze_node
 *   router node of the 8 x 8 mesh: five input paths with XY routing
 *   and one-entry buffers, five output ports with qos arbitration,
 *   no U-turn paths on the mesh directions
 */

`timescale 1ns/1ps

module maze_node import maze_pkg::*; #(
    parameter int LOCAL_X = 0,
    parameter int LOCAL_Y = 0
) (
    input  logic clk,
    input  logic reset_i,

    // inputs, local A and the four neighbors
    input  logic a_vld_i,
    input  pkt_t a_pkt_i,
    output logic a_rdy_o,
    input  logic n_vld_i,
    input  pkt_t n_pkt_i,
    output logic n_rdy_o,
    input  logic w_vld_i,
    input  pkt_t w_pkt_i,
    output logic w_rdy_o,
    input  logic s_vld_i,
    input  pkt_t s_pkt_i,
    output logic s_rdy_o,
    input  logic e_vld_i,
    input  pkt_t e_pkt_i,
    output logic e_rdy_o,

    // outputs, local B and the four neighbors
    output logic b_vld_o,
    output pkt_t b_pkt_o,
    input  logic b_rdy_i,
    output logic n_vld_o,
    output pkt_t n_pkt_o,
    input  logic n_rdy_i,
    output logic w_vld_o,
    output pkt_t w_pkt_o,
    input  logic w_rdy_i,
    output logic s_vld_o,
    output pkt_t s_pkt_o,
    input  logic s_rdy_i,
    output logic e_vld_o,
    output pkt_t e_pkt_o,
    input  logic e_rdy_i
);

    logic [N_PORTS-1:0] in_vld, in_rdy, in_gnt;
    pkt_t               in_pkt  [N_PORTS];
    pkt_t               buf_pkt [N_PORTS];
    route_t             route   [N_PORTS];
    route_t             req     [N_PORTS];      // req[input][output]
    logic [N_PORTS-1:0] gnt_mat [N_PORTS];      // gnt_mat[output][input]
    logic [N_PORTS-1:0] out_vld, out_rdy;
    pkt_t               out_pkt [N_PORTS];

    // port groups to indexed arrays
    assign in_vld[PORT_L] = a_vld_i;
    assign in_vld[PORT_N] = n_vld_i;
    assign in_vld[PORT_W] = w_vld_i;
    assign in_vld[PORT_S] = s_vld_i;
    assign in_vld[PORT_E] = e_vld_i;
    assign in_pkt[PORT_L] = a_pkt_i;
    assign in_pkt[PORT_N] = n_pkt_i;
    assign in_pkt[PORT_W] = w_pkt_i;
    assign in_pkt[PORT_S] = s_pkt_i;
    assign in_pkt[PORT_E] = e_pkt_i;
    assign a_rdy_o = in_rdy[PORT_L];
    assign n_rdy_o = in_rdy[PORT_N];
    assign w_rdy_o = in_rdy[PORT_W];
    assign s_rdy_o = in_rdy[PORT_S];
    assign e_rdy_o = in_rdy[PORT_E];

    assign out_rdy[PORT_L] = b_rdy_i;
    assign out_rdy[PORT_N] = n_rdy_i;
    assign out_rdy[PORT_W] = w_rdy_i;
    assign out_rdy[PORT_S] = s_rdy_i;
    assign out_rdy[PORT_E] = e_rdy_i;
    assign b_vld_o = out_vld[PORT_L];
    assign n_vld_o = out_vld[PORT_N];
    assign w_vld_o = out_vld[PORT_W];
    assign s_vld_o = out_vld[PORT_S];
    assign e_vld_o = out_vld[PORT_E];
    assign b_pkt_o = out_pkt[PORT_L];
    assign n_pkt_o = out_pkt[PORT_N];
    assign w_pkt_o = out_pkt[PORT_W];
    assign s_pkt_o = out_pkt[PORT_S];
    assign e_pkt_o = out_pkt[PORT_E];

    // ========================================================================
    // input paths
    // ========================================================================
    for (genvar i = 0; i < N_PORTS; i++) begin : g_in
        xy_route #(
            .LOCAL_X (LOCAL_X),
            .LOCAL_Y (LOCAL_Y)
        ) i_route (
            .tgt_i   (in_pkt[i].tgt),
            .route_o (route[i])
        );

        input_buffer i_ibuf (
            .clk     (clk),
            .reset_i (reset_i),
            .vld_i   (in_vld[i]),
            .pkt_i   (in_pkt[i]),
            .rdy_o   (in_rdy[i]),
            .route_i (route[i]),
            .gnt_i   (in_gnt[i]),
            .req_o   (req[i]),
            .pkt_o   (buf_pkt[i])
        );
    end

    // an input requests a single output, so at most one bit is set here
    always_comb begin
        in_gnt = '0;
        for (int o = 0; o < N_PORTS; o++) begin
            in_gnt |= gnt_mat[o];
        end
    end

    // ========================================================================
    // mesh outputs, fed by every input except their own direction
    // ========================================================================
    for (genvar o = 0; o < N_PORTS - 1; o++) begin : g_mesh_out
        logic [N_PORTS-2:0] sub_req, sub_gnt;
        pkt_t               sub_pkt [N_PORTS-1];

        for (genvar j = 0; j < N_PORTS - 1; j++) begin : g_fanin
            localparam int SRC = (j < o) ? j : j + 1;   // skip the U-turn
            assign sub_req[j]        = req[SRC][o];
            assign sub_pkt[j]        = buf_pkt[SRC];
            assign gnt_mat[o][SRC]   = sub_gnt[j];
        end
        assign gnt_mat[o][o] = 1'b0;

        output_port #(
            .N_REQ   (N_PORTS - 1)
        ) i_oport (
            .clk     (clk),
            .reset_i (reset_i),
            .req_i   (sub_req),
            .pkts_i  (sub_pkt),
            .gnt_o   (sub_gnt),
            .vld_o   (out_vld[o]),
            .pkt_o   (out_pkt[o]),
            .rdy_i   (out_rdy[o])
        );
    end

    // local B takes all five inputs, loopback included
    logic [N_PORTS-1:0] loc_req;

    for (genvar j = 0; j < N_PORTS; j++) begin : g_loc_fanin
        assign loc_req[j] = req[j][PORT_L];
    end

    output_port #(
        .N_REQ   (N_PORTS)
    ) i_oport_b (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (loc_req),
        .pkts_i  (buf_pkt),
        .gnt_o   (gnt_mat[PORT_L]),
        .vld_o   (out_vld[PORT_L]),
        .pkt_o   (out_pkt[PORT_L]),
        .rdy_i   (out_rdy[PORT_L])
    );

endmodule

/* tests/tb_maze_node.sv */
/*
 * testbench for the mesh router node
 *   clock, reset and per-port stimulus drivers
 *   scoreboard with one queue per input/output pair
 *   concurrent checks on reset state, stalls and loopback latency
 */

`timescale 1ns/1ps

module tb_maze_node import maze_pkg::*; ();

    localparam int NODE_X  = 3;
    localparam int NODE_Y  = 4;
    localparam logic [NODE_ID_W-1:0] SELF = NODE_ID_W'(NODE_Y * MESH_DIM + NODE_X);
    localparam int TIMEOUT = 200;           // cycles per handshake wait

    logic               clk;
    logic               reset_i;
    logic [N_PORTS-1:0] in_vld;
    pkt_t               in_pkt [N_PORTS];
    wire  [N_PORTS-1:0] in_rdy;
    wire  [N_PORTS-1:0] out_vld;
    pkt_t               out_pkt [N_PORTS];
    logic [N_PORTS-1:0] out_rdy;
    logic               rand_rdy;           // random output ready pattern
    logic               loop_chk;           // arms the latency check

    pkt_t exp_q [N_PORTS*N_PORTS][$];       // index input * N_PORTS + output
    int   out_log [N_PORTS][$];             // source index per delivery
    int   n_checks;
    int   n_errors;

    maze_node #(
        .LOCAL_X (NODE_X),
        .LOCAL_Y (NODE_Y)
    ) i_dut (
        .clk     (clk),
        .reset_i (reset_i),
        .a_vld_i (in_vld[PORT_L]), .a_pkt_i (in_pkt[PORT_L]), .a_rdy_o (in_rdy[PORT_L]),
        .n_vld_i (in_vld[PORT_N]), .n_pkt_i (in_pkt[PORT_N]), .n_rdy_o (in_rdy[PORT_N]),
        .w_vld_i (in_vld[PORT_W]), .w_pkt_i (in_pkt[PORT_W]), .w_rdy_o (in_rdy[PORT_W]),
        .s_vld_i (in_vld[PORT_S]), .s_pkt_i (in_pkt[PORT_S]), .s_rdy_o (in_rdy[PORT_S]),
        .e_vld_i (in_vld[PORT_E]), .e_pkt_i (in_pkt[PORT_E]), .e_rdy_o (in_rdy[PORT_E]),
        .b_vld_o (out_vld[PORT_L]), .b_pkt_o (out_pkt[PORT_L]), .b_rdy_i (out_rdy[PORT_L]),
        .n_vld_o (out_vld[PORT_N]), .n_pkt_o (out_pkt[PORT_N]), .n_rdy_i (out_rdy[PORT_N]),
        .w_vld_o (out_vld[PORT_W]), .w_pkt_o (out_pkt[PORT_W]), .w_rdy_i (out_rdy[PORT_W]),
        .s_vld_o (out_vld[PORT_S]), .s_pkt_o (out_pkt[PORT_S]), .s_rdy_i (out_rdy[PORT_S]),
        .e_vld_o (out_vld[PORT_E]), .e_pkt_o (out_pkt[PORT_E]), .e_rdy_i (out_rdy[PORT_E])
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (rand_rdy) begin
            out_rdy = N_PORTS'($urandom) | N_PORTS'($urandom);   // about 3 in 4 high
        end
    end

    // ========================================================================
    // helpers
    // ========================================================================
    function automatic void flag_error(input string msg);
        n_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    // dimension order with x first, then y, then local
    function automatic int expected_port(input logic [NODE_ID_W-1:0] tgt);
        int x;
        int y;
        x = int'(tgt[COORD_W-1:0]);
        y = int'(tgt[NODE_ID_W-1:COORD_W]);
        if (x != NODE_X) return (x > NODE_X) ? PORT_E : PORT_W;
        if (y != NODE_Y) return (y > NODE_Y) ? PORT_N : PORT_S;
        return PORT_L;
    endfunction

    // a mesh input never targets its own direction since that path has no wire
    function automatic logic [NODE_ID_W-1:0] pick_target(input int p);
        logic [NODE_ID_W-1:0] t;
        do begin
            t = NODE_ID_W'($urandom);
        end while (p != PORT_L && expected_port(t) == p);
        return t;
    endfunction

    // src carries the input index so the scoreboard can find its queue
    function automatic pkt_t make_pkt(input int src, input logic [NODE_ID_W-1:0] tgt,
                                      input logic qos);
        pkt_t p;
        p.qos      = qos;
        p.pkt_type = 2'($urandom);
        p.src      = NODE_ID_W'(src);
        p.tgt      = tgt;
        p.data     = DATA_W'($urandom);
        return p;
    endfunction

    function automatic int pending();
        int n = 0;
        for (int k = 0; k < N_PORTS * N_PORTS; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    task automatic end_run();
        $display("%0d packets checked, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("test %-12s %s (%0d errors)", name,
                 (n_errors == err_start) ? "ok" : "failed", n_errors - err_start);
    endtask

    // the packet already offered on input p is taken
    task automatic wait_accept(input int p);
        int   cycles;
        logic taken;
        cycles = 0;
        do begin
            @(posedge clk);
            taken = in_rdy[p];
            cycles++;
        end while (!taken && cycles < TIMEOUT);
        if (!taken) begin
            $display("timeout: input %0d did not accept a packet in %0d cycles", p, TIMEOUT);
            n_errors++;
            end_run();
        end
    endtask

    // vld stays high after the handshake until the caller drops it or sends again
    task automatic send_pkt(input int p, input pkt_t pkt);
        @(negedge clk);
        in_vld[p] = 1'b1;
        in_pkt[p] = pkt;
        wait_accept(p);
    endtask

    task automatic drop_vld(input int p);
        @(negedge clk);
        in_vld[p] = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (pending() > 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (pending() > 0) begin
            $display("timeout: %0d packets still in flight after %0d cycles", pending(), limit);
            n_errors++;
            end_run();
        end
    endtask

    task automatic drive_random(input int p, input int n);
        int gap;
        for (int k = 0; k < n; k++) begin
            send_pkt(p, make_pkt(p, pick_target(p), 1'($urandom)));
            gap = $urandom_range(2, 0);
            if (gap > 0) begin
                drop_vld(p);
                repeat (gap - 1) @(negedge clk);
            end
        end
        drop_vld(p);
    endtask

    // ========================================================================
    // scoreboard
    // ========================================================================
    always @(posedge clk) begin
        int   o_exp;
        int   src;
        pkt_t exp_pkt;
        if (!reset_i) begin
            for (int i = 0; i < N_PORTS; i++) begin
                if (in_vld[i] && in_rdy[i]) begin
                    o_exp = expected_port(in_pkt[i].tgt);
                    exp_q[i*N_PORTS + o_exp].push_back(in_pkt[i]);
                end
            end
            for (int o = 0; o < N_PORTS; o++) begin
                if (out_vld[o] && out_rdy[o]) begin
                    src = int'(out_pkt[o].src);
                    out_log[o].push_back(src);
                    n_checks++;
                    if (src < N_PORTS && exp_q[src*N_PORTS + o].size() > 0) begin
                        exp_pkt = exp_q[src*N_PORTS + o].pop_front();
                        assert (out_pkt[o] == exp_pkt)
                        else flag_error($sformatf("output %0d sent %h, expected %h",
                                                  o, out_pkt[o], exp_pkt));
                    end else begin
                        flag_error($sformatf("output %0d sent unexpected packet %h",
                                             o, out_pkt[o]));
                    end
                end
            end
        end
    end

    // ========================================================================
    // concurrent checks
    // ========================================================================
    a_reset_state : assert property (
        @(posedge clk) $fell(reset_i) |-> (out_vld == '0 && in_rdy == '1)
    ) else flag_error("outputs not idle after reset");

    a_loop_latency : assert property (
        @(posedge clk) disable iff (reset_i)
        (loop_chk && in_vld[PORT_L] && in_rdy[PORT_L]) |-> ##2
        (out_vld[PORT_L] && out_rdy[PORT_L] && out_pkt[PORT_L] == $past(in_pkt[PORT_L], 2))
    ) else flag_error("loopback packet not on B two edges after input");

    for (genvar g = 0; g < N_PORTS; g++) begin : g_hold
        a_hold : assert property (
            @(posedge clk) disable iff (reset_i)
            (out_vld[g] && !out_rdy[g]) |=> (out_vld[g] && $stable(out_pkt[g]))
        ) else flag_error($sformatf("output %0d changed while stalled", g));
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        int err_start;
        clk      = 1'b0;
        reset_i  = 1'b1;
        in_vld   = '0;
        out_rdy  = '1;
        rand_rdy = 1'b0;
        loop_chk = 1'b0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < N_PORTS; i++) begin
            in_pkt[i] = '0;
        end
        void'($urandom(26));

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);                     // reset state checked on this edge
        end_test("reset", 0);

        err_start = n_errors;
        loop_chk  = 1'b1;
        send_pkt(PORT_L, make_pkt(PORT_L, SELF, 1'b0));
        drop_vld(PORT_L);
        wait_drain(TIMEOUT);
        loop_chk = 1'b0;
        assert (out_log[PORT_L].size() == 1) else flag_error("loopback count wrong");
        end_test("loopback", err_start);

        err_start = n_errors;
        rand_rdy  = 1'b1;
        for (int p = 0; p < N_PORTS; p++) begin
            automatic int pp = p;
            fork
                drive_random(pp, 24);
            join_none
        end
        wait fork;
        wait_drain(20 * TIMEOUT);
        @(negedge clk);
        rand_rdy = 1'b0;
        out_rdy  = '1;
        end_test("xy_routing", err_start);

        // filler from N leaves the east pointer on W so only qos can put N first
        err_start = n_errors;
        out_log[PORT_E].delete();
        out_rdy[PORT_E] = 1'b0;
        send_pkt(PORT_N, make_pkt(PORT_N, NODE_ID_W'(6'o46), 1'b0));
        drop_vld(PORT_N);
        send_pkt(PORT_W, make_pkt(PORT_W, NODE_ID_W'(6'o46), 1'b0));
        drop_vld(PORT_W);
        repeat (2) @(negedge clk);
        send_pkt(PORT_N, make_pkt(PORT_N, NODE_ID_W'(6'o47), 1'b1));
        drop_vld(PORT_N);
        repeat (2) @(negedge clk);
        out_rdy[PORT_E] = 1'b1;
        wait_drain(TIMEOUT);
        assert (out_log[PORT_E].size() == 3 && out_log[PORT_E][1] == PORT_N)
        else flag_error("qos packet did not leave first");
        end_test("qos", err_start);

        err_start = n_errors;
        out_log[PORT_L].delete();
        fork
            repeat (6) send_pkt(PORT_W, make_pkt(PORT_W, SELF, 1'b0));
            repeat (6) send_pkt(PORT_S, make_pkt(PORT_S, SELF, 1'b0));
        join
        drop_vld(PORT_W);
        in_vld[PORT_S] = 1'b0;
        wait_drain(TIMEOUT);
        assert (out_log[PORT_L].size() == 12) else flag_error("round-robin count wrong");
        for (int k = 1; k < out_log[PORT_L].size(); k++) begin
            assert (out_log[PORT_L][k] != out_log[PORT_L][k-1])
            else flag_error($sformatf("input %0d won twice in a row", out_log[PORT_L][k]));
        end
        end_test("round_robin", err_start);

        // west stalled with one packet in the slice and one in the input buffer
        err_start = n_errors;
        out_log[PORT_W].delete();
        out_rdy[PORT_W] = 1'b0;
        send_pkt(PORT_E, make_pkt(PORT_E, NODE_ID_W'(6'o21), 1'b0));
        send_pkt(PORT_E, make_pkt(PORT_E, NODE_ID_W'(6'o61), 1'b1));
        @(negedge clk);
        in_pkt[PORT_E] = make_pkt(PORT_E, NODE_ID_W'(6'o40), 1'b0);
        repeat (4) begin
            @(posedge clk);
            assert (!in_rdy[PORT_E]) else flag_error("east input ready with both buffers full");
        end
        @(negedge clk);
        out_rdy[PORT_W] = 1'b1;
        wait_accept(PORT_E);
        drop_vld(PORT_E);
        wait_drain(TIMEOUT);
        assert (out_log[PORT_W].size() == 3) else flag_error("packets lost under back-pressure");
        end_test("backpressure", err_start);

        end_run();
    end

endmodule

/* files.f */
hdl/maze_pkg.sv
hdl/xy_route.sv
hdl/input_buffer.sv
hdl/qos_arbiter.sv
hdl/output_buffer.sv
hdl/output_port.sv
hdl/maze_node.sv
tests/tb_maze_node.sv
